// File: cfg_word_pkg.sv
package cfg_word_pkg;

    // ====================
    // Configuration word layout
    // ====================

    // Full word width
    localparam int CFG_WIDTH     = 16;
    // Opcode lives in the top bits
    localparam int CFG_OP_WIDTH  = 4;
    // Operand lives in the low bits
    localparam int CFG_ARG_WIDTH = 12;

    // Opcodes understood by the CCU decoder
    // Codes not listed here are treated like OP_NOP
    typedef enum logic [CFG_OP_WIDTH-1:0] {
        OP_NOP      = 4'h0,
        // Operand becomes the compute length
        OP_SET_LEN  = 4'h1,
        // Low bits of operand become the block enable mask
        OP_SET_MASK = 4'h2
    } cfg_op_e;

endpackage

// File: ccu_ctrl_pkg.sv
package ccu_ctrl_pkg;

    // ====================
    // CCU control definitions
    // ====================

    // Layer run states
    typedef enum logic [2:0] {
        IDLE    = 3'b000,
        // Collect config words into the command FIFO
        CFG     = 3'b001,
        // Start the PEBs and wait for them
        COMP    = 3'b010,
        // Request to global buffer, waiting for ready
        WAITGBF = 3'b100,
        // Pop and apply the config words
        DECODE  = 3'b101
    } ccu_state_e;

    // Fixed cycles that COMP spends beyond the PEB busy time
    // One start cycle plus one cycle to see busy low
    localparam logic [15:0] COMP_OVERHEAD = 16'd2;

endpackage

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  full,
    output logic                  empty
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Word storage
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Pointers carry one wrap bit above the address
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    // Qualified requests
    logic do_push;
    logic do_pop;

    // Same address with a different wrap bit means full
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    // Pointers equal means empty
    assign empty = (wr_ptr == rd_ptr);

    // Push when full and pop when empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head word visible without a pop
    assign data_out = mem[rd_ptr[ADDR_WIDTH-1:0]];

    // Write side
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= data_in;
        end
    end

    // Pointer update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + (ADDR_WIDTH+1)'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + (ADDR_WIDTH+1)'(1);
            end
        end
    end

endmodule

// File: ccu.sv
`timescale 1ns/1ps

module ccu
    import cfg_word_pkg::*;
    import ccu_ctrl_pkg::*;
#(
    parameter int NUM_PEB         = 4,
    parameter int FIFO_ADDR_WIDTH = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     cfg_push,
    input  logic [CFG_WIDTH-1:0]     cfg_data,
    input  logic                     gb_rdy,
    input  logic [NUM_PEB-1:0]       peb_busy,
    output logic                     cfg_rdy,
    output logic                     gb_cfg_val,
    output logic                     busy,
    output logic                     done,
    output logic [15:0]              comp_cycles,
    output logic                     peb_start,
    output logic [CFG_ARG_WIDTH-1:0] peb_len,
    output logic [NUM_PEB-1:0]       peb_en
);

    // ====================
    // Declarations
    // ====================

    ccu_state_e state;
    ccu_state_e next_state;

    // Command FIFO side
    logic                 fifo_push;
    logic                 fifo_pop;
    logic [CFG_WIDTH-1:0] fifo_out;
    logic                 fifo_full;
    logic                 fifo_empty;

    // Head word fields
    cfg_op_e              cfg_op;
    logic [CFG_ARG_WIDTH-1:0] cfg_arg;

    // Words popped so far in DECODE
    logic [FIFO_ADDR_WIDTH-1:0] dec_cnt;
    logic                       dec_last;

    // Layer settings from the config words
    logic [CFG_ARG_WIDTH-1:0] len_q;
    logic [NUM_PEB-1:0]       mask_q;

    // COMP bookkeeping
    logic [15:0] comp_cnt;
    logic        started;
    logic        all_finish;

    // ====================
    // FSM
    // ====================

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // One layer per start
                if (start) begin
                    next_state = CFG;
                end
            end
            CFG: begin
                if (fifo_full) begin
                    next_state = WAITGBF;
                end
            end
            WAITGBF: begin
                // Hold the request until the buffer answers
                if (gb_rdy) begin
                    next_state = DECODE;
                end
            end
            DECODE: begin
                if (dec_last || fifo_empty) begin
                    next_state = COMP;
                end
            end
            COMP: begin
                if (all_finish) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Status levels straight from the state
    assign cfg_rdy    = (state == CFG);
    assign gb_cfg_val = (state == WAITGBF);
    assign busy       = (state != IDLE);

    // ====================
    // Command FIFO
    // ====================

    // Only words offered during CFG are kept
    assign fifo_push = cfg_push && cfg_rdy;
    // One word per DECODE cycle
    assign fifo_pop  = (state == DECODE) && !fifo_empty;

    sync_fifo #(
        .DATA_WIDTH(CFG_WIDTH),
        .ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) u_fifo_cmd (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (fifo_push),
        .pop     (fifo_pop),
        .data_in (cfg_data),
        .data_out(fifo_out),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // ====================
    // Decoder
    // ====================

    assign cfg_op  = cfg_op_e'(fifo_out[CFG_WIDTH-1 -: CFG_OP_WIDTH]);
    assign cfg_arg = fifo_out[CFG_ARG_WIDTH-1:0];

    // Last pop of a full FIFO
    assign dec_last = fifo_pop && (&dec_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_cnt <= '0;
        end else if (fifo_pop) begin
            dec_cnt <= dec_cnt + FIFO_ADDR_WIDTH'(1);
        end else if (state != DECODE) begin
            dec_cnt <= '0;
        end
    end

    // Later words override earlier ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_q  <= '0;
            mask_q <= '0;
        end else if ((state == IDLE) && start) begin
            // Fresh settings for every layer
            len_q  <= '0;
            mask_q <= '0;
        end else if (fifo_pop) begin
            case (cfg_op)
                OP_SET_LEN:  len_q  <= cfg_arg;
                OP_SET_MASK: mask_q <= cfg_arg[NUM_PEB-1:0];
                // NOP and unknown codes fall through
                default: ;
            endcase
        end
    end

    // ====================
    // Compute phase
    // ====================

    // Start pulse in the first COMP cycle only
    assign peb_start = (state == COMP) && !started;
    assign peb_len   = len_q;
    assign peb_en    = mask_q;

    // Busy must be sampled low after the start, never before
    assign all_finish = started && !(|peb_busy) &&
                        (comp_cnt >= COMP_OVERHEAD - 16'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started  <= 1'b0;
            comp_cnt <= '0;
        end else if (state == COMP) begin
            started  <= 1'b1;
            comp_cnt <= comp_cnt + 16'd1;
        end else begin
            started  <= 1'b0;
            comp_cnt <= '0;
        end
    end

    // Result latched with the done pulse, held until the next run ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done        <= 1'b0;
            comp_cycles <= '0;
        end else begin
            done <= (state == COMP) && all_finish;
            if ((state == COMP) && all_finish) begin
                // Count includes the current cycle
                comp_cycles <= comp_cnt + 16'd1;
            end
        end
    end

endmodule

// File: peb_bank.sv
`timescale 1ns/1ps

module peb_bank
    import cfg_word_pkg::*;
#(
    parameter int NUM_PEB = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     peb_start,
    input  logic [CFG_ARG_WIDTH-1:0] peb_len,
    input  logic [NUM_PEB-1:0]       peb_en,
    output logic [NUM_PEB-1:0]       peb_busy
);

    // Length loaded into each block, at least one cycle
    logic [CFG_ARG_WIDTH-1:0] load_len;

    assign load_len = (peb_len == '0) ? CFG_ARG_WIDTH'(1) : peb_len;

    // ====================
    // Block models
    // ====================

    genvar i;
    generate
        for (i = 0; i < NUM_PEB; i++) begin : g_peb
            // Remaining compute cycles of this block
            logic [CFG_ARG_WIDTH-1:0] cnt;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    cnt <= '0;
                end else if (peb_start && peb_en[i]) begin
                    cnt <= load_len;
                end else if (cnt != '0) begin
                    cnt <= cnt - CFG_ARG_WIDTH'(1);
                end
            end

            // Busy from the cycle after start until the count runs out
            assign peb_busy[i] = (cnt != '0);
        end
    endgenerate

endmodule

// File: accel_ctrl_top.sv
`timescale 1ns/1ps

module accel_ctrl_top
    import cfg_word_pkg::*;
#(
    parameter int NUM_PEB         = 4,
    parameter int FIFO_ADDR_WIDTH = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 cfg_push,
    input  logic [CFG_WIDTH-1:0] cfg_data,
    input  logic                 gb_rdy,
    output logic                 cfg_rdy,
    output logic                 gb_cfg_val,
    output logic                 busy,
    output logic                 done,
    output logic [15:0]          comp_cycles,
    output logic [NUM_PEB-1:0]   peb_busy
);

    // CCU to PEB bank
    logic                     peb_start;
    logic [CFG_ARG_WIDTH-1:0] peb_len;
    logic [NUM_PEB-1:0]       peb_en;

    // Central control
    ccu #(
        .NUM_PEB        (NUM_PEB),
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) u_ccu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg_push   (cfg_push),
        .cfg_data   (cfg_data),
        .gb_rdy     (gb_rdy),
        .peb_busy   (peb_busy),
        .cfg_rdy    (cfg_rdy),
        .gb_cfg_val (gb_cfg_val),
        .busy       (busy),
        .done       (done),
        .comp_cycles(comp_cycles),
        .peb_start  (peb_start),
        .peb_len    (peb_len),
        .peb_en     (peb_en)
    );

    // Processing element blocks
    peb_bank #(
        .NUM_PEB(NUM_PEB)
    ) u_peb_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .peb_start(peb_start),
        .peb_len  (peb_len),
        .peb_en   (peb_en),
        .peb_busy (peb_busy)
    );

endmodule

// File: tb_accel_ctrl.sv
`timescale 1ns/1ps

module tb_accel_ctrl
    import cfg_word_pkg::*;
    import ccu_ctrl_pkg::*;
;

    // ====================
    // Setup
    // ====================

    localparam int NUM_PEB   = 4;
    localparam int NUM_TESTS = 8;
    // Fields per stimulus line
    localparam int FIELDS    = 8;
    localparam logic [31:0] SEED = 32'h91a4_5d37;
    // SET_LEN 0x30 word offered while the FIFO is full
    localparam logic [15:0] EXTRA_WORD = 16'h1030;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic                 cfg_push;
    logic [CFG_WIDTH-1:0] cfg_data;
    logic                 gb_rdy;
    logic                 cfg_rdy;
    logic                 gb_cfg_val;
    logic                 busy;
    logic                 done;
    logic [15:0]          comp_cycles;
    logic [NUM_PEB-1:0]   peb_busy;

    // Eight fields per layer as w0 w1 w2 w3 delay extra mask cycles
    logic [15:0] stim [NUM_TESTS*FIELDS];

    int mismatch_cnt;
    int fail_cnt;
    int cycle_cnt;
    int cycle_limit;

    accel_ctrl_top #(
        .NUM_PEB        (NUM_PEB),
        .FIFO_ADDR_WIDTH(2)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg_push   (cfg_push),
        .cfg_data   (cfg_data),
        .gb_rdy     (gb_rdy),
        .cfg_rdy    (cfg_rdy),
        .gb_cfg_val (gb_cfg_val),
        .busy       (busy),
        .done       (done),
        .comp_cycles(comp_cycles),
        .peb_busy   (peb_busy)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycle limit guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish");
            $display("errors: mismatch %0d, other %0d", mismatch_cnt, fail_cnt + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    // Step to 2 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_cycles(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_mask(input string name, input logic [NUM_PEB-1:0] got,
                              input logic [NUM_PEB-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    // Last SET_LEN word wins
    function automatic logic [15:0] final_length(input int base);
        logic [15:0] len;
        len = 16'd0;
        for (int k = 0; k < 4; k++) begin
            if (cfg_op_e'(stim[base+k][CFG_WIDTH-1 -: CFG_OP_WIDTH]) == OP_SET_LEN) begin
                len = {4'h0, stim[base+k][CFG_ARG_WIDTH-1:0]};
            end
        end
        return len;
    endfunction

    // One full layer from start to done
    task automatic run_layer(input int t);
        int                 base;
        int                 gap;
        logic [15:0]        len;
        logic [15:0]        exp_busy;
        logic [15:0]        busy_cnt;
        logic [NUM_PEB-1:0] exp_mask;
        logic [15:0]        exp_cycles;
        base       = t * FIELDS;
        len        = final_length(base);
        exp_mask   = stim[base+6][NUM_PEB-1:0];
        exp_cycles = stim[base+7];
        // Busy time is max(len, 1) or zero for an empty mask
        exp_busy   = (exp_mask == '0) ? 16'd0 : ((len == 16'd0) ? 16'd1 : len);
        if (exp_busy + COMP_OVERHEAD != exp_cycles) begin
            $display("stimulus line %0d has a comp_cycles value that breaks the rule", t);
            fail_cnt++;
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_level("cfg_rdy", cfg_rdy, 1'b1);
        check_level("busy", busy, 1'b1);
        // Fill with random idle gaps
        for (int k = 0; k < 4; k++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                next_cycle();
            end
            check_level("cfg_rdy", cfg_rdy, 1'b1);
            cfg_push = 1'b1;
            cfg_data = stim[base+k];
            next_cycle();
            cfg_push = 1'b0;
        end
        // Optional extra word while the FIFO is full
        cfg_push = stim[base+5][0];
        cfg_data = EXTRA_WORD;
        next_cycle();
        cfg_push = 1'b0;
        check_level("cfg_rdy", cfg_rdy, 1'b0);
        // Request held through the buffer delay
        repeat (stim[base+4]) begin
            check_level("gb_cfg_val", gb_cfg_val, 1'b1);
            check_mask("peb_busy", peb_busy, '0);
            next_cycle();
        end
        check_level("gb_cfg_val", gb_cfg_val, 1'b1);
        gb_rdy = 1'b1;
        next_cycle();
        gb_rdy = 1'b0;
        check_level("gb_cfg_val", gb_cfg_val, 1'b0);
        // Decode and compute until done
        busy_cnt = 16'd0;
        while (done !== 1'b1) begin
            if (peb_busy !== '0) begin
                check_mask("peb_busy", peb_busy, exp_mask);
                busy_cnt++;
            end
            next_cycle();
        end
        check_cycles("comp_cycles", comp_cycles, exp_cycles);
        check_cycles("peb_busy cycles", busy_cnt, exp_busy);
        check_level("busy", busy, 1'b0);
        next_cycle();
        // Single done pulse and held result
        check_level("done", done, 1'b0);
        check_cycles("comp_cycles", comp_cycles, exp_cycles);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        cfg_push     = 1'b0;
        cfg_data     = '0;
        gb_rdy       = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        cycle_limit  = 8 + 40;
        void'($urandom(SEED));
        // Address-based marker to detect a short file
        for (int i = 0; i < NUM_TESTS * FIELDS; i++) begin
            stim[i] = ~16'(i);
        end
        $readmemh("ccu_stim.txt", stim);
        if (stim[NUM_TESTS*FIELDS-1] == ~16'(NUM_TESTS * FIELDS - 1)) begin
            $display("stimulus file ccu_stim.txt could not be read in full");
            fail_cnt++;
        end else begin
            cycle_limit = 0;
            for (int t = 0; t < NUM_TESTS; t++) begin
                cycle_limit += 40 + stim[t*FIELDS+4] + final_length(t * FIELDS);
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Reset values
        check_level("cfg_rdy", cfg_rdy, 1'b0);
        check_level("gb_cfg_val", gb_cfg_val, 1'b0);
        check_level("busy", busy, 1'b0);
        check_level("done", done, 1'b0);
        check_mask("peb_busy", peb_busy, '0);
        check_cycles("comp_cycles", comp_cycles, 16'd0);
        if (fail_cnt == 0) begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_layer(t);
            end
        end
        $display("errors: mismatch %0d, other %0d", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: ccu_stim.txt
// w0   w1   w2   w3   gb_delay extra_push exp_mask exp_comp_cycles
// all hex, one layer per line
1005 200F 0000 0000 0003 0000 000F 0007
2003 1008 7123 0000 0000 0001 0003 000A
1000 2005 0000 0000 0002 0000 0005 0003
1006 2000 0000 0000 0001 0001 0000 0002
1003 1009 2001 2008 0005 0000 0008 000B
F00C 2004 100A 0000 0004 0001 0004 000C
2006 0FFF 1002 2009 0000 0000 0009 0004
100C 2002 1001 000C 0007 0001 0002 0003

// File: filelist.f
cfg_word_pkg.sv
ccu_ctrl_pkg.sv
sync_fifo.sv
ccu.sv
peb_bank.sv
accel_ctrl_top.sv
tb_accel_ctrl.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_accel_ctrl
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
